//--- hdl/quad_ctrl_config.svh
`ifndef QUAD_CTRL_CONFIG_SVH
`define QUAD_CTRL_CONFIG_SVH

// Row buffer BRAM geometry
`define QC_ROW_BUF_DEPTH 1024
`define QC_ROW_W         ($clog2(`QC_ROW_BUF_DEPTH))

// Engines and compute elements
`define QC_NUM_AWE    4
`define QC_CE_PER_AWE 2
`define QC_NUM_CE     (`QC_NUM_AWE * `QC_CE_PER_AWE)

// 3x3 window pass, last cycle index and counter width
`define QC_WIN_LAST 5
`define QC_CYC_W    3

`define QC_PFB_CNT_W  10
`define QC_SEQ_ADDR_W 12
`define QC_PRIME_ROWS 4

`endif

//--- hdl/quad_ctrl_pkg.sv
package quad_ctrl_pkg;

    `include "quad_ctrl_config.svh"

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME_BUFFER,
        ST_WAIT_PFB_LOAD,
        ST_CE_ACTIVE,
        ST_WAIT_JOB_DONE,
        ST_SEND_COMPLETE
    } qc_state_e;

    // Job geometry, stable for the whole job
    typedef struct packed {
        logic [`QC_ROW_W-1:0] expd_num_input_cols;
        logic [`QC_ROW_W-1:0] expd_num_input_rows;
        logic [`QC_ROW_W-1:0] num_output_rows;
        logic [`QC_ROW_W-1:0] num_output_cols;
    } qc_job_cfg_t;

    // Sequencer to PFB scan strobes
    typedef struct packed {
        logic read_req;
        logic load;
        logic clear;
    } qc_scan_ctrl_t;

    typedef struct packed {
        logic [`QC_PFB_CNT_W-1:0] pfb_count;
        logic [`QC_ROW_W-1:0]     input_row;
        logic                     pfb_empty;
        logic                     pfb_full;
    } qc_scan_stat_t;

    // Sequencer to sequence reader strobes
    typedef struct packed {
        logic start_pass;
        logic clear;
    } qc_seq_ctrl_t;

    typedef struct packed {
        logic                 seq_rden_r;
        logic [`QC_CYC_W-1:0] cycle_counter;
        logic                 window_end;   // last window of an output row
        logic                 last_out_row;
    } qc_seq_stat_t;

endpackage

//--- hdl/job_sequencer.sv
`include "quad_ctrl_config.svh"

module job_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         job_start,
    input  logic                         job_fetch_ack,
    input  logic                         job_fetch_complete,
    input  logic                         job_complete_ack,
    input  logic                         last_kernel,
    input  logic                         pipeline_flushed,
    input  quad_ctrl_pkg::qc_job_cfg_t   job_cfg,
    input  quad_ctrl_pkg::qc_scan_stat_t scan_stat,
    input  quad_ctrl_pkg::qc_seq_stat_t  seq_stat,
    input  logic                         pass_end,
    output logic                         job_accept,
    output logic                         job_fetch_request,
    output logic                         job_fetch_in_progress,
    output logic                         job_complete,
    output quad_ctrl_pkg::qc_state_e     state,
    output logic [1:0]                   gray_code,
    output logic                         pip_primed,
    output quad_ctrl_pkg::qc_scan_ctrl_t scan_ctrl,
    output quad_ctrl_pkg::qc_seq_ctrl_t  seq_ctrl
);
    import quad_ctrl_pkg::*;

    qc_state_e  return_state;
    qc_state_e  pass_next;
    logic [1:0] gray_cnt;
    logic       fetch_done;
    logic       prime_done;
    logic       rows_done;

    assign fetch_done = job_fetch_complete && job_fetch_in_progress;
    // Fourth row loaded and untouched
    assign prime_done = (scan_stat.input_row == `QC_PRIME_ROWS - 1) && scan_stat.pfb_full;
    assign rows_done  = scan_stat.input_row == job_cfg.expd_num_input_rows + 1'b1;
    assign gray_code  = {gray_cnt[1], ^gray_cnt};

    // Where the FSM goes at the end of the current pass
    always_comb begin
        pass_next = ST_CE_ACTIVE;
        if (scan_stat.pfb_empty && last_kernel) begin
            if (rows_done && seq_stat.last_out_row) begin
                pass_next = ST_WAIT_JOB_DONE;
            end else if (!rows_done) begin
                pass_next = ST_WAIT_PFB_LOAD;
            end
        end
    end

    always_comb begin
        scan_ctrl       = '0;
        scan_ctrl.load  = fetch_done;
        scan_ctrl.clear = job_complete_ack;
        case (state)
            ST_PRIME_BUFFER: scan_ctrl.read_req = !prime_done;
            ST_CE_ACTIVE:    scan_ctrl.read_req = last_kernel;
            default:         scan_ctrl.read_req = 1'b0;
        endcase
    end

    always_comb begin
        seq_ctrl.start_pass = (state == ST_PRIME_BUFFER && prime_done)
                           || (state == ST_CE_ACTIVE && pass_end && pass_next == ST_CE_ACTIVE)
                           || (state == ST_WAIT_PFB_LOAD && fetch_done
                               && return_state == ST_CE_ACTIVE);
        seq_ctrl.clear      = job_complete_ack
                           || (state == ST_CE_ACTIVE && pass_end
                               && pass_next == ST_WAIT_JOB_DONE);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_ack) begin
            job_fetch_in_progress <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            return_state      <= ST_IDLE;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            pip_primed        <= 1'b0;
            gray_cnt          <= 2'd0;
        end else begin
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME_BUFFER;
                    end
                end
                ST_PRIME_BUFFER: begin
                    if (prime_done) begin
                        pip_primed <= 1'b1;
                        state      <= ST_CE_ACTIVE;
                    end else if (scan_stat.pfb_empty) begin
                        return_state <= ST_PRIME_BUFFER;
                        state        <= ST_WAIT_PFB_LOAD;
                    end
                end
                ST_WAIT_PFB_LOAD: begin
                    // Held until the ack, low again the cycle after
                    job_fetch_request <= !job_fetch_in_progress && !job_fetch_ack;
                    if (fetch_done) begin
                        state <= return_state;
                    end
                end
                ST_CE_ACTIVE: begin
                    if (pass_end) begin
                        state        <= pass_next;
                        return_state <= ST_CE_ACTIVE;
                        if (pass_next == ST_WAIT_JOB_DONE) begin
                            gray_cnt <= 2'd0;
                        end else if (last_kernel) begin
                            gray_cnt <= gray_cnt + 2'd1;
                        end
                    end
                end
                ST_WAIT_JOB_DONE: begin
                    if (pipeline_flushed) begin
                        state <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    job_complete <= !job_complete_ack;
                    if (job_complete_ack) begin
                        pip_primed <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/pixel_buffer_scan.sv
`include "quad_ctrl_config.svh"

module pixel_buffer_scan (
    input  logic                         clk,
    input  logic                         rst,
    input  quad_ctrl_pkg::qc_scan_ctrl_t scan_ctrl,
    input  logic [`QC_PFB_CNT_W-1:0]     pfb_full_count,
    input  logic [`QC_ROW_W-1:0]         expd_num_input_cols,
    input  logic                         pip_primed,
    output logic                         pfb_rden,
    output logic [`QC_ROW_W-1:0]         input_row,
    output logic [`QC_ROW_W-1:0]         input_col,
    output quad_ctrl_pkg::qc_scan_stat_t scan_stat
);

    logic [`QC_PFB_CNT_W-1:0] pfb_count;
    logic                     last_word;
    logic                     col_wrap;

    // Read in flight on the final buffered word
    assign last_word = (pfb_count == 1) && pfb_rden;
    assign col_wrap  = (input_col == expd_num_input_cols) && (pip_primed ? last_word : pfb_rden);

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_rden  <= 1'b0;
            pfb_count <= '0;
        end else begin
            // Count is one cycle stale, so skip a word already being read
            pfb_rden <= scan_ctrl.read_req && !scan_ctrl.clear
                     && (pfb_count > 1 || (pfb_count == 1 && !pfb_rden));
            if (scan_ctrl.clear) begin
                pfb_count <= '0;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end else if (scan_ctrl.load) begin
                pfb_count <= pfb_full_count;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Input scan position
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
        end else if (scan_ctrl.clear) begin
            input_row <= '0;
            input_col <= '0;
        end else if (col_wrap) begin
            input_col <= '0;
            input_row <= input_row + 1'b1;
        end else if (pfb_rden) begin
            input_col <= input_col + 1'b1;
        end
    end

    always_comb begin
        scan_stat.pfb_count = pfb_count;
        scan_stat.input_row = input_row;
        scan_stat.pfb_empty = pfb_count == '0;
        scan_stat.pfb_full  = pfb_count == pfb_full_count;
    end

endmodule

//--- hdl/pixel_seq_reader.sv
`include "quad_ctrl_config.svh"

module pixel_seq_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  quad_ctrl_pkg::qc_seq_ctrl_t seq_ctrl,
    input  logic [`QC_SEQ_ADDR_W-1:0]   pix_seq_data_full_count,
    input  logic [`QC_ROW_W-1:0]        num_output_cols,
    input  logic [`QC_ROW_W-1:0]        num_output_rows,
    input  logic                        last_kernel,
    output logic [`QC_SEQ_ADDR_W-1:0]   pix_seq_bram_rdAddr,
    output quad_ctrl_pkg::qc_seq_stat_t seq_stat
);

    logic [`QC_SEQ_ADDR_W-1:0] seq_count;
    logic [`QC_SEQ_ADDR_W-1:0] seq_left;
    logic                      seq_rden_r;
    logic [`QC_CYC_W-1:0]      cycle_counter;
    logic [`QC_ROW_W-1:0]      output_row;
    logic [`QC_ROW_W-1:0]      output_col;
    logic                      window_done;

    // Words left once this cycle's strobe lands
    assign seq_left    = seq_rden_r ? seq_count - 1'b1 : seq_count;
    assign window_done = cycle_counter == `QC_WIN_LAST;

    ////////////////////////////////////////////////////////////
    // Sequence BRAM read, one burst per pass
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_count           <= '0;
            seq_rden_r          <= 1'b0;
            pix_seq_bram_rdAddr <= '0;
        end else if (seq_ctrl.clear) begin
            seq_count           <= '0;
            seq_rden_r          <= 1'b0;
            pix_seq_bram_rdAddr <= '0;
        end else if (seq_ctrl.start_pass) begin
            seq_count           <= pix_seq_data_full_count;
            seq_rden_r          <= 1'b0;
            pix_seq_bram_rdAddr <= '0;
        end else begin
            seq_count           <= seq_left;
            seq_rden_r          <= seq_left > 1;
            if (seq_rden_r) begin
                pix_seq_bram_rdAddr <= pix_seq_bram_rdAddr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || seq_ctrl.clear) begin
            cycle_counter <= '0;
        end else if (window_done) begin
            cycle_counter <= '0;
        end else if (seq_rden_r) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    // Output position, the row moves only after the last kernel
    always_ff @(posedge clk) begin
        if (rst || seq_ctrl.clear) begin
            output_row <= '0;
            output_col <= '0;
        end else if (window_done) begin
            if (output_col == num_output_cols) begin
                output_col <= '0;
                if (last_kernel) begin
                    output_row <= output_row + 1'b1;
                end
            end else begin
                output_col <= output_col + 1'b1;
            end
        end
    end

    always_comb begin
        seq_stat.seq_rden_r    = seq_rden_r;
        seq_stat.cycle_counter = cycle_counter;
        seq_stat.window_end    = window_done && (output_col == num_output_cols);
        seq_stat.last_out_row  = output_row == num_output_rows;
    end

endmodule

//--- hdl/ce_dispatch.sv
`include "quad_ctrl_config.svh"

module ce_dispatch (
    input  logic                        clk,
    input  logic                        rst,
    input  quad_ctrl_pkg::qc_seq_stat_t seq_stat,
    input  logic [`QC_CYC_W-1:0]        last_awe_ce1_cyc_counter,
    output logic                        pix_seq_bram_rden,
    output logic [`QC_NUM_CE-1:0]       ce_execute,
    output logic [`QC_NUM_CE-1:0]       next_kernel,
    output logic                        pass_end
);

    // Bit n holds the read strobe delayed by n+1 cycles
    logic [2:0] rden_dly;

    // BRAM enable stretched over its three cycle read latency
    assign pix_seq_bram_rden = seq_stat.seq_rden_r | rden_dly[1] | rden_dly[2];

    // Chain drained and last CE on its final window cycle
    assign pass_end = (ce_execute == '0) && (last_awe_ce1_cyc_counter == `QC_WIN_LAST);

    ////////////////////////////////////////////////////////////
    // CE shift chains, one CE per cycle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rden_dly    <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            rden_dly    <= {rden_dly[1:0], seq_stat.seq_rden_r};
            ce_execute  <= {ce_execute[`QC_NUM_CE-2:0], rden_dly[1]};
            next_kernel <= {next_kernel[`QC_NUM_CE-2:0], seq_stat.window_end};
        end
    end

endmodule

//--- hdl/quad_bram_ctrl.sv
`include "quad_ctrl_config.svh"

module quad_bram_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`QC_ROW_W-1:0]      expd_num_input_cols,
    input  logic [`QC_ROW_W-1:0]      expd_num_input_rows,
    input  logic [`QC_ROW_W-1:0]      num_output_rows,
    input  logic [`QC_ROW_W-1:0]      num_output_cols,
    input  logic                      job_start,
    output logic                      job_accept,
    output logic                      job_fetch_request,
    output logic                      job_fetch_in_progress,
    input  logic                      job_fetch_ack,
    input  logic                      job_fetch_complete,
    output logic                      job_complete,
    input  logic                      job_complete_ack,
    output quad_ctrl_pkg::qc_state_e  state,
    output logic [`QC_ROW_W-1:0]      input_row,
    output logic [`QC_ROW_W-1:0]      input_col,
    output logic [1:0]                gray_code,
    output logic                      pfb_rden,
    input  logic [`QC_PFB_CNT_W-1:0]  pfb_full_count,
    output logic [`QC_NUM_CE-1:0]     ce_execute,
    output logic [`QC_CYC_W-1:0]      cycle_counter,
    input  logic [`QC_CYC_W-1:0]      last_awe_ce1_cyc_counter,
    output logic                      pix_seq_bram_rden,
    output logic [`QC_SEQ_ADDR_W-1:0] pix_seq_bram_rdAddr,
    input  logic [`QC_SEQ_ADDR_W-1:0] pix_seq_data_full_count,
    output logic [`QC_NUM_CE-1:0]     next_kernel,
    input  logic                      last_kernel,
    input  logic                      pipeline_flushed
);
    import quad_ctrl_pkg::*;

    qc_job_cfg_t   job_cfg;
    qc_scan_ctrl_t scan_ctrl;
    qc_scan_stat_t scan_stat;
    qc_seq_ctrl_t  seq_ctrl;
    qc_seq_stat_t  seq_stat;
    logic          pip_primed;
    logic          pass_end;

    assign job_cfg = '{
        expd_num_input_cols: expd_num_input_cols,
        expd_num_input_rows: expd_num_input_rows,
        num_output_rows:     num_output_rows,
        num_output_cols:     num_output_cols
    };
    assign cycle_counter = seq_stat.cycle_counter;

    job_sequencer u_job_sequencer (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .last_kernel           (last_kernel),
        .pipeline_flushed      (pipeline_flushed),
        .job_cfg               (job_cfg),
        .scan_stat             (scan_stat),
        .seq_stat              (seq_stat),
        .pass_end              (pass_end),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .state                 (state),
        .gray_code             (gray_code),
        .pip_primed            (pip_primed),
        .scan_ctrl             (scan_ctrl),
        .seq_ctrl              (seq_ctrl)
    );

    pixel_buffer_scan u_pixel_buffer_scan (
        .clk                 (clk),
        .rst                 (rst),
        .scan_ctrl           (scan_ctrl),
        .pfb_full_count      (pfb_full_count),
        .expd_num_input_cols (expd_num_input_cols),
        .pip_primed          (pip_primed),
        .pfb_rden            (pfb_rden),
        .input_row           (input_row),
        .input_col           (input_col),
        .scan_stat           (scan_stat)
    );

    pixel_seq_reader u_pixel_seq_reader (
        .clk                     (clk),
        .rst                     (rst),
        .seq_ctrl                (seq_ctrl),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .num_output_cols         (num_output_cols),
        .num_output_rows         (num_output_rows),
        .last_kernel             (last_kernel),
        .pix_seq_bram_rdAddr     (pix_seq_bram_rdAddr),
        .seq_stat                (seq_stat)
    );

    ce_dispatch u_ce_dispatch (
        .clk                      (clk),
        .rst                      (rst),
        .seq_stat                 (seq_stat),
        .last_awe_ce1_cyc_counter (last_awe_ce1_cyc_counter),
        .pix_seq_bram_rden        (pix_seq_bram_rden),
        .ce_execute               (ce_execute),
        .next_kernel              (next_kernel),
        .pass_end                 (pass_end)
    );

endmodule

//--- sim/quad_ctrl_properties.sv
`include "quad_ctrl_config.svh"

module quad_ctrl_properties (
    input logic                      clk,
    input logic                      rst,
    input logic                      job_start,
    input logic                      job_accept,
    input logic                      job_fetch_request,
    input logic                      job_fetch_ack,
    input logic                      job_fetch_in_progress,
    input logic                      job_complete,
    input logic                      job_complete_ack,
    input quad_ctrl_pkg::qc_state_e  state,
    input logic [`QC_ROW_W-1:0]      input_row,
    input logic [`QC_ROW_W-1:0]      input_col,
    input logic [`QC_ROW_W-1:0]      expd_num_input_cols,
    input logic                      pfb_rden,
    input logic                      pix_seq_bram_rden,
    input logic [`QC_NUM_CE-1:0]     ce_execute,
    input logic [`QC_NUM_CE-1:0]     next_kernel,
    input logic [1:0]                gray_code,
    input logic [`QC_CYC_W-1:0]      cycle_counter,
    input logic [`QC_SEQ_ADDR_W-1:0] pix_seq_bram_rdAddr
);
    timeunit 1ns;
    timeprecision 100ps;
    import quad_ctrl_pkg::*;

    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Host and fetch handshakes
    ////////////////////////////////////////////////////////////
    a_accept_pulse: assert property (@(posedge clk) disable iff (rst)
        job_accept |=> !job_accept)
        else begin
            fail_count++;
            $error("job_accept lasted more than one cycle");
        end

    a_accept_cause: assert property (@(posedge clk) disable iff (rst)
        job_accept |-> $past(job_start) && $past(state) == ST_IDLE)
        else begin
            fail_count++;
            $error("job_accept without job_start in the idle state");
        end

    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && !job_fetch_ack |=> job_fetch_request)
        else begin
            fail_count++;
            $error("job_fetch_request dropped before job_fetch_ack");
        end

    a_fetch_drop: assert property (@(posedge clk) disable iff (rst)
        job_fetch_ack |=> !job_fetch_request)
        else begin
            fail_count++;
            $error("job_fetch_request still high after job_fetch_ack");
        end

    a_complete_hold: assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else begin
            fail_count++;
            $error("job_complete dropped before job_complete_ack");
        end

    // Ack also clears the scan position
    a_complete_drop: assert property (@(posedge clk) disable iff (rst)
        job_complete_ack |=> !job_complete && input_row == '0 && input_col == '0)
        else begin
            fail_count++;
            $error("job_complete or scan position not cleared after ack");
        end

    ////////////////////////////////////////////////////////////
    // PFB scan position
    ////////////////////////////////////////////////////////////
    a_col_wrap: assert property (@(posedge clk) disable iff (rst)
        pfb_rden && input_col == expd_num_input_cols
        |=> input_col == '0 && input_row == $past(input_row) + 1'b1)
        else begin
            fail_count++;
            $error("input_col did not wrap into the next row");
        end

    a_col_step: assert property (@(posedge clk) disable iff (rst)
        pfb_rden && input_col != expd_num_input_cols |=> input_col == $past(input_col) + 1'b1)
        else begin
            fail_count++;
            $error("input_col did not step on pfb_rden");
        end

    ////////////////////////////////////////////////////////////
    // Window cycle counter
    ////////////////////////////////////////////////////////////
    a_cyc_wrap: assert property (@(posedge clk) disable iff (rst)
        cycle_counter == `QC_WIN_LAST |=> cycle_counter == '0)
        else begin
            fail_count++;
            $error("cycle_counter did not return to zero after the last window cycle");
        end

    // Mid window the burst is continuous
    a_cyc_step: assert property (@(posedge clk) disable iff (rst)
        cycle_counter != '0 && cycle_counter != `QC_WIN_LAST
        |=> cycle_counter == $past(cycle_counter) + 1'b1)
        else begin
            fail_count++;
            $error("cycle_counter did not step inside a window");
        end

    ////////////////////////////////////////////////////////////
    // CE chains
    ////////////////////////////////////////////////////////////
    a_ce_start: assert property (@(posedge clk) disable iff (rst)
        $rose(pix_seq_bram_rden) |-> ##3 $rose(ce_execute[0]))
        else begin
            fail_count++;
            $error("ce_execute[0] did not start three cycles after the read burst");
        end

    a_ce_chain: assert property (@(posedge clk) disable iff (rst)
        ce_execute[`QC_NUM_CE-1:1] == $past(ce_execute[`QC_NUM_CE-2:0]))
        else begin
            fail_count++;
            $error("ce_execute chain did not shift by one cycle");
        end

    a_kernel_chain: assert property (@(posedge clk) disable iff (rst)
        next_kernel[`QC_NUM_CE-1:1] == $past(next_kernel[`QC_NUM_CE-2:0]))
        else begin
            fail_count++;
            $error("next_kernel chain did not shift by one cycle");
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !job_accept && !job_fetch_request && !job_fetch_in_progress
            && !job_complete && !pfb_rden && !pix_seq_bram_rden && ce_execute == '0
            && next_kernel == '0 && gray_code == '0 && state == ST_IDLE)
        else begin
            fail_count++;
            $error("control outputs not quiet during or right after reset");
        end

    a_addr_done: assert property (@(posedge clk) disable iff (rst)
        state == ST_SEND_COMPLETE |-> pix_seq_bram_rdAddr == '0)
        else begin
            fail_count++;
            $error("sequence read address not cleared at job completion");
        end

endmodule

//--- sim/tb_quad_bram_ctrl.sv
`include "quad_ctrl_config.svh"

module tb_quad_bram_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import quad_ctrl_pkg::*;

    localparam int ACCEPT_LIMIT   = 50;
    localparam int COMPLETE_LIMIT = 20000;
    localparam int NUM_JOBS       = 4;

    logic                      clk;
    logic                      rst;
    logic [`QC_ROW_W-1:0]      expd_num_input_cols;
    logic [`QC_ROW_W-1:0]      expd_num_input_rows;
    logic [`QC_ROW_W-1:0]      num_output_rows;
    logic [`QC_ROW_W-1:0]      num_output_cols;
    logic                      job_start;
    logic                      job_accept;
    logic                      job_fetch_request;
    logic                      job_fetch_in_progress;
    logic                      job_fetch_ack;
    logic                      job_fetch_complete;
    logic                      job_complete;
    logic                      job_complete_ack;
    qc_state_e                 state;
    logic [`QC_ROW_W-1:0]      input_row;
    logic [`QC_ROW_W-1:0]      input_col;
    logic [1:0]                gray_code;
    logic                      pfb_rden;
    logic [`QC_PFB_CNT_W-1:0]  pfb_full_count;
    logic [`QC_NUM_CE-1:0]     ce_execute;
    logic [`QC_CYC_W-1:0]      cycle_counter;
    logic [`QC_CYC_W-1:0]      last_awe_ce1_cyc_counter;
    logic                      pix_seq_bram_rden;
    logic [`QC_SEQ_ADDR_W-1:0] pix_seq_bram_rdAddr;
    logic [`QC_SEQ_ADDR_W-1:0] pix_seq_data_full_count;
    logic [`QC_NUM_CE-1:0]     next_kernel;
    logic                      last_kernel;
    logic                      pipeline_flushed;

    int unsigned seed = 12478;
    int          timeouts = 0;
    int          errors;
    // Cycle counter history, eleven cycles deep
    logic [10:0][`QC_CYC_W-1:0] cyc_pipe = '0;

    quad_bram_ctrl DUT (.*);

    bind quad_bram_ctrl quad_ctrl_properties u_props (.*);

    function int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Responders and last CE model
    ////////////////////////////////////////////////////////////
    initial begin
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (job_fetch_request) begin
                repeat (lcg_next() % 4) begin
                    @(posedge clk);
                    #2;
                end
                job_fetch_ack = 1'b1;
                @(posedge clk);
                #2 job_fetch_ack = 1'b0;
                repeat (lcg_next() % 4 + 1) begin
                    @(posedge clk);
                    #2;
                end
                job_fetch_complete = 1'b1;
                @(posedge clk);
                #2 job_fetch_complete = 1'b0;
            end
        end
    end

    // Last CE sees the window count eleven cycles after the reader
    initial begin
        last_awe_ce1_cyc_counter = '0;
        forever begin
            @(posedge clk);
            cyc_pipe <= {cyc_pipe[9:0], cycle_counter};
            #2 last_awe_ce1_cyc_counter = cyc_pipe[10];
        end
    end

    initial begin
        pipeline_flushed = 1'b0;
        forever begin
            @(posedge clk);
            #2 pipeline_flushed = (state == ST_WAIT_JOB_DONE) && (lcg_next() % 2 == 1);
        end
    end

    // One job with random geometry, one PFB load per input row
    task run_job(input int idx);
        int unsigned cols;
        int unsigned rows;
        int unsigned wins;
        int          cnt;
        cols = 1 + lcg_next() % 4;
        rows = 3 + lcg_next() % 4;
        wins = 1 + lcg_next() % 2;
        expd_num_input_cols     = cols;
        expd_num_input_rows     = rows;
        num_output_cols         = wins - 1;
        num_output_rows         = rows - 2 + lcg_next() % 3;
        pfb_full_count          = cols + 1;
        pix_seq_data_full_count = 6 * wins + 1;
        job_start = 1'b1;
        cnt = 0;
        while (!job_accept && cnt < ACCEPT_LIMIT) begin
            @(posedge clk);
            #2;
            cnt++;
        end
        job_start = 1'b0;
        if (!job_accept) begin
            $display("timeout: job %0d was never accepted", idx);
            timeouts++;
            return;
        end
        cnt = 0;
        while (!job_complete && cnt < COMPLETE_LIMIT) begin
            @(posedge clk);
            #2;
            cnt++;
        end
        if (!job_complete) begin
            $display("timeout: job %0d never raised job_complete", idx);
            timeouts++;
            return;
        end
        repeat (lcg_next() % 4) begin
            @(posedge clk);
            #2;
        end
        job_complete_ack = 1'b1;
        @(posedge clk);
        #2 job_complete_ack = 1'b0;
        repeat (3) @(posedge clk);
        #2;
    endtask

    initial begin
        rst                     = 1'b1;
        job_start               = 1'b0;
        job_complete_ack        = 1'b0;
        last_kernel             = 1'b1;
        expd_num_input_cols     = '0;
        expd_num_input_rows     = '0;
        num_output_rows         = '0;
        num_output_cols         = '0;
        pfb_full_count          = '0;
        pix_seq_data_full_count = '0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        for (int j = 0; j < NUM_JOBS && timeouts == 0; j++) begin
            run_job(j);
        end
        repeat (20) @(posedge clk);
        errors = DUT.u_props.fail_count;
        $display("assertion failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hdl
hdl/quad_ctrl_pkg.sv
hdl/job_sequencer.sv
hdl/pixel_buffer_scan.sv
hdl/pixel_seq_reader.sv
hdl/ce_dispatch.sv
hdl/quad_bram_ctrl.sv
sim/quad_ctrl_properties.sv
sim/tb_quad_bram_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_quad_bram_ctrl -o tb_sim &&
./obj_dir/tb_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -q "ALL TESTS PASSED" && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
